// ==== compile.f ====
logic/c2f_ring_pkg.sv
logic/pdu_pkg.sv
logic/c2f_csr_if.sv
logic/c2f_apb_regs.sv
logic/c2f_fetch_ctrl.sv
logic/pdu_meta_capture.sv
logic/stream_fifo.sv
logic/c2f_dma_top.sv
verification/c2f_dma_properties.sv
verification/c2f_dma_tb.sv

// ==== logic/c2f_apb_regs.sv ====
`timescale 1ns/1ns

module c2f_apb_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    c2f_csr_if.regs     csr
);

    logic [31:0]           kmem_lo;
    logic [31:0]           kmem_hi;
    logic [31:0]           done_lo;
    logic [31:0]           done_hi;
    c2f_ring_pkg::rb_idx_t tail_q;
    logic                  access;
    logic                  mapped;
    logic                  wr_ok;

    // no wait states
    assign access = psel && penable;
    assign pready = access;

    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            c2f_ring_pkg::REG_KMEM_LO: prdata = kmem_lo;
            c2f_ring_pkg::REG_KMEM_HI: prdata = kmem_hi;
            c2f_ring_pkg::REG_DONE_LO: prdata = done_lo;
            c2f_ring_pkg::REG_DONE_HI: prdata = done_hi;
            c2f_ring_pkg::REG_TAIL:    prdata = 32'(tail_q);
            c2f_ring_pkg::REG_HEAD:    prdata = 32'(csr.head);
            default:                   mapped = 1'b0;
        endcase
    end

    // head belongs to the controller, so writing it is an error
    assign pslverr = access && (!mapped || (pwrite && paddr == c2f_ring_pkg::REG_HEAD));
    assign wr_ok   = access && pwrite && !pslverr;

    always_ff @(posedge clk) begin
        if (rst) begin
            kmem_lo <= '0;
            kmem_hi <= '0;
            done_lo <= '0;
            done_hi <= '0;
            tail_q  <= '0;
        end else if (wr_ok) begin
            case (paddr)
                c2f_ring_pkg::REG_KMEM_LO: kmem_lo <= pwdata;
                c2f_ring_pkg::REG_KMEM_HI: kmem_hi <= pwdata;
                c2f_ring_pkg::REG_DONE_LO: done_lo <= pwdata;
                c2f_ring_pkg::REG_DONE_HI: done_hi <= pwdata;
                // tail doorbell, upper bits dropped
                c2f_ring_pkg::REG_TAIL:
                    tail_q <= pwdata[c2f_ring_pkg::C2F_RB_AWIDTH-1:0];
                default: ;
            endcase
        end
    end

    assign csr.kmem_addr = {kmem_hi, kmem_lo};
    assign csr.done_addr = {done_hi, done_lo};
    assign csr.tail      = tail_q;

endmodule

// ==== logic/c2f_csr_if.sv ====
`timescale 1ns/1ns

interface c2f_csr_if;

    // ring base in host memory
    logic [63:0]                 kmem_addr;
    // where the new head gets written back
    logic [63:0]                 done_addr;
    c2f_ring_pkg::rb_idx_t       tail;
    c2f_ring_pkg::rb_idx_t       head;

    modport regs (
        output kmem_addr, done_addr, tail,
        input  head
    );

    modport ctrl (
        input  kmem_addr, done_addr, tail,
        output head
    );

endinterface

// ==== logic/c2f_dma_top.sv ====
`timescale 1ns/1ns

module c2f_dma_top (
    input  logic                    clk,
    input  logic                    rst,
    // cpu register access
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [31:0]             paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    // read data mover descriptors
    output logic                    rddm_desc_valid,
    output c2f_ring_pkg::dm_desc_t  rddm_desc_data,
    input  logic                    rddm_desc_ready,
    // write data mover priority port
    output logic                    wrdm_prio_valid,
    output c2f_ring_pkg::dm_desc_t  wrdm_prio_data,
    input  logic                    wrdm_prio_ready,
    // lines written by the read data mover
    input  logic                    c2f_write,
    input  logic [511:0]            c2f_writedata,
    input  c2f_ring_pkg::rb_idx_t   c2f_address,
    // metadata to packet logic
    output logic                    pdumeta_valid,
    output pdu_pkg::pdu_meta_t      pdumeta_data,
    input  logic                    pdumeta_ready
);

    c2f_csr_if csr ();

    logic                           desc_valid;
    c2f_ring_pkg::dm_desc_t         desc_data;
    logic                           desc_in_ready;
    logic                           desc_full;
    logic [pdu_pkg::META_CNT_W-1:0] meta_count;
    logic                           fetch_start;
    c2f_ring_pkg::rb_idx_t          fetch_size;
    logic                           fetch_done;
    logic                           cap_valid;
    pdu_pkg::pdu_meta_t             cap_data;

    assign desc_full = !desc_in_ready;

    c2f_apb_regs regs0 (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .csr(csr.regs)
    );

    c2f_fetch_ctrl ctrl0 (
        .clk(clk), .rst(rst),
        .csr(csr.ctrl),
        .meta_count(meta_count),
        .desc_valid(desc_valid), .desc_data(desc_data), .desc_full(desc_full),
        .prio_valid(wrdm_prio_valid), .prio_data(wrdm_prio_data),
        .prio_ready(wrdm_prio_ready),
        .fetch_start(fetch_start), .fetch_size(fetch_size), .fetch_done(fetch_done)
    );

    pdu_meta_capture cap0 (
        .clk(clk), .rst(rst),
        .c2f_write(c2f_write), .c2f_writedata(c2f_writedata), .c2f_address(c2f_address),
        .fetch_start(fetch_start), .fetch_size(fetch_size), .fetch_done(fetch_done),
        .meta_valid(cap_valid), .meta_data(cap_data)
    );

    stream_fifo #(.payload_t(c2f_ring_pkg::dm_desc_t), .DEPTH(4)) desc_fifo (
        .clk(clk), .rst(rst),
        .in_valid(desc_valid), .in_data(desc_data), .in_ready(desc_in_ready),
        .out_valid(rddm_desc_valid), .out_data(rddm_desc_data), .out_ready(rddm_desc_ready),
        .count()
    );

    // room check upstream keeps this from ever filling
    stream_fifo #(
        .payload_t(pdu_pkg::pdu_meta_t),
        .DEPTH(pdu_pkg::META_FIFO_DEPTH)
    ) meta_fifo (
        .clk(clk), .rst(rst),
        .in_valid(cap_valid), .in_data(cap_data), .in_ready(),
        .out_valid(pdumeta_valid), .out_data(pdumeta_data), .out_ready(pdumeta_ready),
        .count(meta_count)
    );

endmodule

// ==== logic/c2f_fetch_ctrl.sv ====
`timescale 1ns/1ns

module c2f_fetch_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    c2f_csr_if.ctrl                         csr,
    input  logic [pdu_pkg::META_CNT_W-1:0]  meta_count,
    output logic                            desc_valid,
    output c2f_ring_pkg::dm_desc_t          desc_data,
    input  logic                            desc_full,
    output logic                            prio_valid,
    output c2f_ring_pkg::dm_desc_t          prio_data,
    input  logic                            prio_ready,
    output logic                            fetch_start,
    output c2f_ring_pkg::rb_idx_t           fetch_size,
    input  logic                            fetch_done
);

    typedef enum logic [2:0] {
        s_idle,
        s_desc,
        s_desc_low,
        s_desc_high,
        s_done,
        s_wait
    } state_t;

    state_t                          state;
    c2f_ring_pkg::rb_idx_t           head_q;
    c2f_ring_pkg::rb_idx_t           new_head;
    c2f_ring_pkg::rb_idx_t           size_q;
    logic                            lines_done;
    logic                            room_ok;
    logic                            first_go;
    logic [pdu_pkg::META_CNT_W:0]    room_need;
    logic [63:0]                     head_src;

    // read descriptor for a run of ring lines, 16 dwords per line
    function automatic c2f_ring_pkg::dm_desc_t data_desc(
        input logic [63:0]           src,
        input c2f_ring_pkg::rb_idx_t lines
    );
        c2f_ring_pkg::dm_desc_t d;
        d           = '0;
        d.dword_cnt = 18'({lines, 4'b0000});
        d.dst_addr  = {32'd0, c2f_ring_pkg::EP_BASE_ADDR};
        d.src_addr  = src;
        return d;
    endfunction

    // each ring line is 64 bytes
    assign head_src  = csr.kmem_addr + {52'd0, head_q, 6'd0};

    // metadata FIFO must absorb the whole fetch
    assign room_need = meta_count + size_q;
    assign room_ok   = room_need < pdu_pkg::META_ROOM_LIMIT;

    assign first_go    = (state == s_desc || state == s_desc_low) && room_ok && !desc_full;
    assign desc_valid  = first_go || (state == s_desc_high && !desc_full);
    assign fetch_start = first_go;
    assign fetch_size  = size_q;

    always_comb begin
        case (state)
            // wrapped span, lines from head up to the end of the ring
            s_desc_low:  desc_data = data_desc(head_src, 6'd0 - head_q);
            // rest of the wrap restarts at the ring base
            s_desc_high: desc_data = data_desc(csr.kmem_addr, new_head);
            default:     desc_data = data_desc(head_src, size_q);
        endcase
    end

    // head write-back rides as immediate data
    always_comb begin
        prio_data           = '0;
        prio_data.desc_id   = c2f_ring_pkg::DONE_ID;
        prio_data.immediate = 1'b1;
        prio_data.dword_cnt = 18'd1;
        prio_data.dst_addr  = csr.done_addr;
        prio_data.src_addr  = 64'(new_head);
    end

    assign prio_valid = (state == s_done);
    assign csr.head   = head_q;

    // capture may finish before the done descriptor is taken
    always_ff @(posedge clk) begin
        if (rst) begin
            lines_done <= 1'b0;
        end else if (fetch_start) begin
            lines_done <= 1'b0;
        end else if (fetch_done) begin
            lines_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= s_idle;
            head_q   <= '0;
            new_head <= '0;
            size_q   <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (csr.tail != head_q) begin
                        new_head <= csr.tail;
                        // ring arithmetic wraps for free in 6 bits
                        size_q   <= csr.tail - head_q;
                        if (csr.tail > head_q || csr.tail == '0) begin
                            state <= s_desc;
                        end else begin
                            state <= s_desc_low;
                        end
                    end
                end
                s_desc: begin
                    if (first_go) begin
                        state <= s_done;
                    end
                end
                s_desc_low: begin
                    if (first_go) begin
                        state <= s_desc_high;
                    end
                end
                s_desc_high: begin
                    if (!desc_full) begin
                        state <= s_done;
                    end
                end
                s_done: begin
                    if (prio_ready) begin
                        head_q <= new_head;
                        state  <= s_wait;
                    end
                end
                s_wait: begin
                    if (lines_done || fetch_done) begin
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

// ==== logic/c2f_ring_pkg.sv ====
package c2f_ring_pkg;

    // host ring geometry
    localparam int C2F_RB_DEPTH  = 64;
    localparam int C2F_RB_AWIDTH = 6;

    typedef logic [C2F_RB_AWIDTH-1:0] rb_idx_t;

    // fetched lines land here in endpoint memory
    localparam logic [31:0] EP_BASE_ADDR = 32'h0004_0000;

    // ID carried by the head write-back descriptor
    localparam logic [7:0] DONE_ID = 8'hFD;

    // data-mover descriptor, 174 bits, msb first
    typedef struct packed {
        logic [13:0] func_num;
        logic [7:0]  desc_id;
        logic [2:0]  app_bits;
        logic        rsvd;
        logic        single_dst;
        logic        immediate;
        logic [17:0] dword_cnt;
        logic [63:0] dst_addr;
        // source address, or the payload itself when immediate
        logic [63:0] src_addr;
    } dm_desc_t;

    // APB register map, byte offsets
    localparam logic [31:0] REG_KMEM_LO = 32'h0000_0000;
    localparam logic [31:0] REG_KMEM_HI = 32'h0000_0004;
    localparam logic [31:0] REG_DONE_LO = 32'h0000_0008;
    localparam logic [31:0] REG_DONE_HI = 32'h0000_000C;
    localparam logic [31:0] REG_TAIL    = 32'h0000_0010;
    localparam logic [31:0] REG_HEAD    = 32'h0000_0014;

endpackage

// ==== logic/pdu_meta_capture.sv ====
`timescale 1ns/1ns

module pdu_meta_capture (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   c2f_write,
    input  logic [511:0]           c2f_writedata,
    input  c2f_ring_pkg::rb_idx_t  c2f_address,
    input  logic                   fetch_start,
    input  c2f_ring_pkg::rb_idx_t  fetch_size,
    output logic                   fetch_done,
    output logic                   meta_valid,
    output pdu_pkg::pdu_meta_t     meta_data
);

    pdu_pkg::pdu_hdr_t     hdr;
    c2f_ring_pkg::rb_idx_t line_cnt;
    c2f_ring_pkg::rb_idx_t size_q;
    logic                  active;
    logic                  take;

    assign hdr = c2f_writedata;

    // slot offset is relative to the fetch window, never past its size
    assign take = c2f_write && active && (c2f_address < size_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            line_cnt   <= '0;
            size_q     <= '0;
            active     <= 1'b0;
            fetch_done <= 1'b0;
        end else begin
            fetch_done <= 1'b0;
            if (fetch_start) begin
                line_cnt <= '0;
                size_q   <= fetch_size;
                active   <= 1'b1;
            end else if (take) begin
                line_cnt <= line_cnt + 1'b1;
                // last line of this fetch
                if (c2f_ring_pkg::rb_idx_t'(line_cnt + 1'b1) == size_q) begin
                    active     <= 1'b0;
                    fetch_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            meta_valid <= 1'b0;
        end else begin
            meta_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        meta_data.tuple        <= hdr.tuple;
        meta_data.pcie_address <= hdr.pcie_address;
    end

endmodule

// ==== logic/pdu_pkg.sv ====
package pdu_pkg;

    // one 512-bit ring line as the host lays it out
    typedef struct packed {
        logic [383:0] rsvd;
        logic [31:0]  pcie_address;
        logic [95:0]  tuple;
    } pdu_hdr_t;

    // what the packet logic needs from each line
    typedef struct packed {
        logic [95:0] tuple;
        logic [31:0] pcie_address;
    } pdu_meta_t;

    localparam int META_FIFO_DEPTH = 128;
    // occupancy counter width, must hold 0..META_FIFO_DEPTH
    localparam int META_CNT_W      = $clog2(META_FIFO_DEPTH + 1);

    // a fetch may start only while size + occupancy stays below this
    localparam int META_ROOM_LIMIT = 120;

endpackage

// ==== logic/stream_fifo.sv ====
`timescale 1ns/1ns

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         in_valid,
    input  payload_t                     in_data,
    output logic                         in_ready,
    output logic                         out_valid,
    output payload_t                     out_data,
    input  logic                         out_ready,
    output logic [$clog2(DEPTH+1)-1:0]   count
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          push;
    logic          pop;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_ready = (count < CW'(DEPTH));
    assign push     = in_valid && in_ready;
    assign pop      = out_valid && out_ready;
    assign out_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10: begin
                    count     <= count + 1'b1;
                    out_valid <= 1'b1;
                end
                // drops only when the last entry leaves
                2'b01: begin
                    count     <= count - 1'b1;
                    out_valid <= (count != CW'(1));
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the c2f DMA testbench with Verilator, pass is decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module c2f_dma_tb \
    -o c2f_dma_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/c2f_dma_sim > sim.log 2>&1 || true
cat sim.log
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verification/c2f_dma_properties.sv ====
`timescale 1ns/1ns

module c2f_dma_properties (
    input logic                   clk,
    input logic                   rst,
    input logic [2:0]             state,
    input logic                   desc_valid,
    input logic                   desc_full,
    input logic                   prio_valid,
    input logic                   prio_ready,
    input c2f_ring_pkg::dm_desc_t prio_data,
    input logic                   fetch_start,
    input c2f_ring_pkg::rb_idx_t  fetch_size
);

    // done descriptor holds until the write data mover takes it
    prio_hold: assert property (@(posedge clk) disable iff (rst)
        prio_valid && !prio_ready |=> prio_valid && $stable(prio_data))
        else $error("done descriptor changed while stalled");

    // desc, desc_low and desc_high are left only on a push the FIFO takes
    advance_on_push: assert property (@(posedge clk) disable iff (rst)
        (state inside {3'd1, 3'd2, 3'd3}) && !(desc_valid && !desc_full) |=> $stable(state))
        else $error("controller moved past a descriptor the FIFO did not take");

    prio_idle_after_reset: assert property (@(posedge clk) rst |=> !prio_valid)
        else $error("prio_valid high right after reset");

    nonzero_fetch: assert property (@(posedge clk) disable iff (rst)
        fetch_start |-> fetch_size != '0)
        else $error("fetch started with zero size");

endmodule

// ==== verification/c2f_dma_tb.sv ====
`timescale 1ns/1ns

module c2f_dma_tb;

    typedef struct packed {
        logic [5:0] tail;
        logic [1:0] n_desc;
        logic [5:0] size_lo;
        logic [5:0] size_hi;
        logic       hold;
    } row_t;

    localparam int          WAIT_LIMIT = 2000;
    localparam logic [63:0] KMEM       = 64'h0000_0012_8765_4000;
    localparam logic [63:0] DONE       = 64'h0000_0003_1234_5670;

    // new tail, descriptor count, low size, high size, metadata stalled
    row_t scen [7] = '{
        '{6'd5,  2'd1, 6'd5,  6'd0,  1'b0},
        '{6'd20, 2'd1, 6'd15, 6'd0,  1'b1},
        '{6'd60, 2'd1, 6'd40, 6'd0,  1'b0},
        '{6'd10, 2'd2, 6'd4,  6'd10, 1'b1},
        '{6'd0,  2'd1, 6'd54, 6'd0,  1'b0},
        '{6'd63, 2'd1, 6'd63, 6'd0,  1'b1},
        '{6'd2,  2'd2, 6'd1,  6'd2,  1'b0}
    };

    logic                   clk             = 1'b0;
    logic                   rst             = 1'b1;
    logic                   psel            = 1'b0;
    logic                   penable         = 1'b0;
    logic                   pwrite          = 1'b0;
    logic [31:0]            paddr           = '0;
    logic [31:0]            pwdata          = '0;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   rddm_desc_valid;
    c2f_ring_pkg::dm_desc_t rddm_desc_data;
    logic                   rddm_desc_ready = 1'b0;
    logic                   wrdm_prio_valid;
    c2f_ring_pkg::dm_desc_t wrdm_prio_data;
    logic                   wrdm_prio_ready = 1'b0;
    logic                   c2f_write       = 1'b0;
    logic [511:0]           c2f_writedata   = '0;
    c2f_ring_pkg::rb_idx_t  c2f_address     = '0;
    logic                   pdumeta_valid;
    pdu_pkg::pdu_meta_t     pdumeta_data;
    logic                   pdumeta_ready   = 1'b1;

    c2f_ring_pkg::dm_desc_t rd_desc_q [$];
    c2f_ring_pkg::dm_desc_t prio_q [$];
    logic [127:0]           meta_exp_q [$];
    int                     lines_left  = 0;
    int                     line_ofs    = 0;
    int                     lines_sent  = 0;
    int                     error_count = 0;

    c2f_dma_top dut0 (.*);

    bind c2f_fetch_ctrl c2f_dma_properties props0 (
        .clk(clk), .rst(rst), .state(state), .desc_valid(desc_valid), .desc_full(desc_full),
        .prio_valid(prio_valid), .prio_ready(prio_ready), .prio_data(prio_data),
        .fetch_start(fetch_start), .fetch_size(fetch_size)
    );

    always #4 clk = ~clk;

    task automatic fail_now(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_value(input string what, input logic [127:0] got,
                                 input logic [127:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("MISMATCH %0t ns: %s is %0h, expected %0h",
                               $time, what, got, exp));
        end
    endtask

    task automatic apb_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int waited;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        waited = 0;
        @(posedge clk);
        while (!pready && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clk);
        end
        if (!pready) begin
            fail_now("APB access never completed, pready stayed low");
        end
        rdata = prdata;
        err   = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic reg_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        compare_value($sformatf("pslverr on write to %0h", addr), err, exp_err);
    endtask

    task automatic reg_read(input logic [31:0] addr, input logic [31:0] exp,
                            input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, 32'd0, rdata, err);
        compare_value($sformatf("pslverr on read of %0h", addr), err, exp_err);
        if (!exp_err) begin
            compare_value($sformatf("read data at %0h", addr), rdata, exp);
        end
    endtask

    // random back-pressure on both descriptor ports
    always @(posedge clk) begin
        rddm_desc_ready <= ($urandom % 4) != 0;
        wrdm_prio_ready <= ($urandom % 3) != 0;
    end

    // host memory side, one ring line per cycle for each accepted read descriptor
    always @(posedge clk) begin
        logic [511:0] line;
        c2f_write <= 1'b0;
        if (!rst && wrdm_prio_valid && wrdm_prio_ready) begin
            prio_q.push_back(wrdm_prio_data);
        end
        if (!rst && rddm_desc_valid && rddm_desc_ready) begin
            rd_desc_q.push_back(rddm_desc_data);
            lines_left += int'(rddm_desc_data.dword_cnt) / 16;
        end
        if (!rst && lines_left > 0) begin
            for (int i = 0; i < 16; i++) begin
                line[i*32 +: 32] = $urandom;
            end
            c2f_write     <= 1'b1;
            c2f_writedata <= line;
            c2f_address   <= 6'(line_ofs);
            // tuple in the low 96 bits, pcie_address right above it
            meta_exp_q.push_back({line[95:0], line[127:96]});
            line_ofs++;
            lines_sent++;
            lines_left--;
        end
    end

    always @(posedge clk) begin
        logic [127:0] exp;
        if (!rst && pdumeta_valid && pdumeta_ready) begin
            if (meta_exp_q.size() == 0) begin
                fail_now("metadata record arrived with no ring line outstanding");
            end else begin
                exp = meta_exp_q.pop_front();
                compare_value("pdumeta tuple", pdumeta_data.tuple, exp[127:32]);
                compare_value("pdumeta pcie_address", pdumeta_data.pcie_address, exp[31:0]);
            end
        end
    end

    initial begin
        c2f_ring_pkg::dm_desc_t d;
        int                     head;
        int                     waited;
        int                     total;
        int                     sz;
        void'($urandom(32'h46d30975));
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // register map
        reg_read(c2f_ring_pkg::REG_HEAD, 32'd0, 1'b0);
        reg_read(c2f_ring_pkg::REG_KMEM_LO, 32'd0, 1'b0);
        reg_write(c2f_ring_pkg::REG_KMEM_LO, KMEM[31:0], 1'b0);
        reg_write(c2f_ring_pkg::REG_KMEM_HI, KMEM[63:32], 1'b0);
        reg_write(c2f_ring_pkg::REG_DONE_LO, DONE[31:0], 1'b0);
        reg_write(c2f_ring_pkg::REG_DONE_HI, DONE[63:32], 1'b0);
        reg_read(c2f_ring_pkg::REG_KMEM_LO, KMEM[31:0], 1'b0);
        reg_read(c2f_ring_pkg::REG_KMEM_HI, KMEM[63:32], 1'b0);
        reg_read(c2f_ring_pkg::REG_DONE_LO, DONE[31:0], 1'b0);
        reg_read(c2f_ring_pkg::REG_DONE_HI, DONE[63:32], 1'b0);
        reg_read(32'h0000_0018, 32'd0, 1'b1);
        reg_write(32'h0000_0040, 32'd1, 1'b1);
        reg_write(c2f_ring_pkg::REG_HEAD, 32'd5, 1'b1);
        reg_read(c2f_ring_pkg::REG_HEAD, 32'd0, 1'b0);

        head = 0;
        for (int r = 0; r < 7; r++) begin
            @(posedge clk);
            pdumeta_ready <= !scen[r].hold;
            line_ofs   = 0;
            lines_sent = 0;
            total      = int'(scen[r].size_lo) + int'(scen[r].size_hi);
            // junk above the index must be dropped
            reg_write(c2f_ring_pkg::REG_TAIL, {26'($urandom), scen[r].tail}, 1'b0);
            reg_read(c2f_ring_pkg::REG_TAIL, 32'(scen[r].tail), 1'b0);

            waited = 0;
            while ((rd_desc_q.size() < int'(scen[r].n_desc) || prio_q.size() == 0)
                   && waited < WAIT_LIMIT) begin
                waited++;
                @(posedge clk);
            end
            if (rd_desc_q.size() < int'(scen[r].n_desc) || prio_q.size() == 0) begin
                fail_now($sformatf("timeout waiting for descriptors of fetch %0d", r));
            end
            for (int k = 0; k < int'(scen[r].n_desc); k++) begin
                d  = rd_desc_q[k];
                sz = (k == 0) ? int'(scen[r].size_lo) : int'(scen[r].size_hi);
                compare_value("rddm dword count", d.dword_cnt, 16 * sz);
                compare_value("rddm source", d.src_addr, (k == 0) ? KMEM + 64'(head * 64) : KMEM);
                compare_value("rddm destination", d.dst_addr, 64'(c2f_ring_pkg::EP_BASE_ADDR));
                compare_value("rddm immediate flag", d.immediate, 1'b0);
            end
            d = prio_q.pop_front();
            compare_value("done immediate flag", d.immediate, 1'b1);
            compare_value("done dword count", d.dword_cnt, 1);
            compare_value("done descriptor id", d.desc_id, c2f_ring_pkg::DONE_ID);
            compare_value("done destination", d.dst_addr, DONE);
            compare_value("done data", d.src_addr, 64'(scen[r].tail));
            reg_read(c2f_ring_pkg::REG_HEAD, 32'(scen[r].tail), 1'b0);

            if (scen[r].hold) begin
                waited = 0;
                while ((lines_sent < total || !pdumeta_valid) && waited < WAIT_LIMIT) begin
                    waited++;
                    @(posedge clk);
                end
                if (lines_sent < total || !pdumeta_valid) begin
                    fail_now("timeout waiting for ring lines while metadata was stalled");
                end
                compare_value("oldest record held during stall", pdumeta_data, meta_exp_q[0]);
                pdumeta_ready <= 1'b1;
            end

            waited = 0;
            while ((lines_sent < total || meta_exp_q.size() != 0) && waited < WAIT_LIMIT) begin
                waited++;
                @(posedge clk);
            end
            if (lines_sent < total || meta_exp_q.size() != 0) begin
                fail_now($sformatf("timeout waiting for metadata records of fetch %0d", r));
            end
            compare_value("data descriptors in fetch", rd_desc_q.size(), scen[r].n_desc);
            rd_desc_q.delete();
            head = int'(scen[r].tail);
        end

        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
